// ==== Bender.yml ====
package:
  name: neuron_layer

sources:
  - files:
      - logic/layerPkg.sv
      - logic/coeffRom.sv
      - logic/coeffArbiter.sv
      - logic/neuronEngine.sv
      - logic/neuronLayer.sv
  - target: test
    files:
      - bench/neuronLayerTb.sv

// ==== bench/neuronLayerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronLayerTb;
	import layerPkg::*;

	localparam int numRandom = 200;
	localparam int numTransfers = numRandom + 3; // zero vector, two directed, then random
	localparam int resetCycles = 16;
	// four cycles per ROM word through the arbiter, doubled for hold time and slack
	localparam int transferBudget = 2 * numNeurons * wordsPerNeuron * 4 + 16;
	localparam int cycleLimit = resetCycles + numTransfers * transferBudget;

	logic clk;
	logic reset;
	logic req;
	logic ack;
	logic signed [actWidth-1:0] act [numInputs];
	logic [actWidth-1:0] result [numNeurons];

	logic signed [actWidth-1:0] stimVec [numInputs];
	logic [actWidth-1:0] expected [numNeurons];
	string testName;
	logic [15:0] lfsrState;
	int transferCount;
	int checkedCount;
	int cycleCount;
	logic ackSeen;
	logic prevReq;
	logic prevAck;

	neuronLayer uut
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.ack(ack),
		.act(act),
		.result(result)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		logic feedback;
		feedback = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], feedback};
	endfunction

	function automatic logic [7:0] randomByte();
		logic [7:0] value;
		for (int k = 0; k < 8; k++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value[k] = lfsrState[0];
		end
		return value;
	endfunction

	function automatic logic signed [7:0] tableWeight(input int n, input int i);
		romWord_t word;
		word = coeffTable[n * wordsPerNeuron + i];
		return $signed(word.weight[0]);
	endfunction

	// weighted sum plus bias, then the saturating ReLU
	function automatic logic [7:0] refNeuron(input int n);
		romWord_t word;
		int total;
		word = coeffTable[n * wordsPerNeuron + numInputs];
		total = int'(word.bias);
		for (int i = 0; i < numInputs; i++)
			total = total + int'(stimVec[i]) * int'(tableWeight(n, i));
		if (total < 0)
			return 8'd0;
		if (total >= 8192) // anything at bit 13 or above
			return 8'd127;
		return 8'((total >> 6) & 255) + 8'((total >> 5) & 1);
	endfunction

	task automatic doTransfer(input string name, input int holdCycles);
		testName = name;
		for (int n = 0; n < numNeurons; n++)
			expected[n] = refNeuron(n);
		transferCount++;
		@(posedge clk);
		for (int i = 0; i < numInputs; i++)
			act[i] <= stimVec[i];
		req <= 1'b1;
		do @(negedge clk); while (!ack);
		repeat (holdCycles) @(posedge clk); // ack must stay up meanwhile
		@(posedge clk);
		req <= 1'b0;
		do @(negedge clk); while (ack);
	endtask

	// compare once per transfer, on the cycle ack comes up
	always @(negedge clk)
	begin
		if (!reset && ack && !ackSeen)
		begin
			for (int n = 0; n < numNeurons; n++)
				assert (result[n] == expected[n])
				else abortRun($sformatf("ERROR %s neuron %0d expected %0d actual %0d",
					testName, n, expected[n], result[n]));
			checkedCount++;
		end
		ackSeen = ack;
	end

	always @(negedge clk)
	begin
		assert (!(ack && !prevAck) || (req && prevReq))
		else abortRun("ack rose while req was low");
		assert (!(!ack && prevAck) || !req)
		else abortRun("ack dropped while req was still high");
		prevReq = req;
		prevAck = ack;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
			abortRun($sformatf("timeout after %0d cycles, %0d of %0d transfers checked",
				cycleCount, checkedCount, numTransfers));
	end

	initial
	begin
		reset = 1'b1;
		req = 1'b0;
		for (int i = 0; i < numInputs; i++)
		begin
			act[i] = '0;
			stimVec[i] = '0;
		end
		lfsrState = 16'd47428;
		transferCount = 0;
		checkedCount = 0;
		cycleCount = 0;
		ackSeen = 1'b0;
		prevReq = 1'b0;
		prevAck = 1'b0;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;

		@(negedge clk);
		assert (ack == 1'b0) else abortRun("ack is high right after reset");
		for (int n = 0; n < numNeurons; n++)
			assert (result[n] == 8'd0)
			else abortRun($sformatf("ERROR reset neuron %0d expected 0 actual %0d",
				n, result[n]));

		doTransfer("zeroInput", 0);
		assert (result[0] == 8'd8)
		else abortRun($sformatf("ERROR zeroInput bias expected 8 actual %0d", result[0]));
		assert (result[3] == 8'd2) // 96 has bit 5 set
		else abortRun($sformatf("ERROR zeroInput rounding expected 2 actual %0d", result[3]));

		// every product of neuron 0 pulls the sum down
		for (int i = 0; i < numInputs; i++)
			stimVec[i] = (tableWeight(0, i) < 0) ? 8'sd127 : -8'sd128;
		doTransfer("reluNegative", 2);
		assert (result[0] == 8'd0)
		else abortRun($sformatf("ERROR reluNegative expected 0 actual %0d", result[0]));

		for (int i = 0; i < numInputs; i++)
			stimVec[i] = (tableWeight(0, i) < 0) ? -8'sd128 : 8'sd127;
		doTransfer("reluSaturate", 0);
		assert (result[0] == 8'd127)
		else abortRun($sformatf("ERROR reluSaturate expected 127 actual %0d", result[0]));

		// req comes back as soon as ack is gone
		for (int t = 0; t < numRandom; t++)
		begin
			for (int i = 0; i < numInputs; i++)
				stimVec[i] = $signed(randomByte());
			doTransfer($sformatf("random%0d", t), t % 3);
		end

		@(negedge clk);
		if (checkedCount == transferCount)
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else
			abortRun($sformatf("only %0d of %0d transfers were checked",
				checkedCount, transferCount));
	end

endmodule

`default_nettype wire

// ==== logic/coeffArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module coeffArbiter
(
	input logic clk,
	input logic reset,
	input logic [layerPkg::numNeurons-1:0] coeffReq,
	input logic [layerPkg::romAddrWidth-1:0] coeffAddr [layerPkg::numNeurons],
	output logic [layerPkg::numNeurons-1:0] coeffAck,
	output layerPkg::romWord_t coeffData,
	output logic [layerPkg::romAddrWidth-1:0] romAddr,
	input layerPkg::romWord_t romData
);
	import layerPkg::*;

	logic [1:0] state;
	logic [$clog2(numNeurons)-1:0] owner; // the next search starts after the engine served last
	logic [$clog2(numNeurons)-1:0] nextOwner;
	logic found;

	always_comb
	begin
		int candidate;
		nextOwner = owner;
		found = 1'b0;
		for (int i = 1; i <= numNeurons; i++)
		begin
			candidate = (int'(owner) + i) % numNeurons;
			if (!found && coeffReq[candidate])
			begin
				nextOwner = candidate[$clog2(numNeurons)-1:0];
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= arbIdle;
			owner <= '0;
			coeffAck <= '0;
		end
		else
		begin
			case (state)
				arbIdle:
					if (found)
					begin
						owner <= nextOwner;
						state <= arbRead;
					end
				arbRead:
				begin
					coeffAck[owner] <= 1'b1; // rom word is out after this edge
					state <= arbAck;
				end
				arbAck:
					if (!coeffReq[owner])
					begin
						coeffAck <= '0;
						state <= arbIdle;
					end
				default: state <= arbIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == arbIdle && found)
			romAddr <= coeffAddr[nextOwner];
	end

	// address stays put until the next grant so the rom output holds too
	assign coeffData = romData;

endmodule

`default_nettype wire

// ==== logic/coeffRom.sv ====
`timescale 1ns/1ps
`default_nettype none

module coeffRom
(
	input logic clk,
	input logic [layerPkg::romAddrWidth-1:0] addr,
	output layerPkg::romWord_t data
);
	import layerPkg::*;

	// one cycle read latency
	always_ff @(posedge clk)
	begin
		data <= coeffTable[addr];
	end

endmodule

`default_nettype wire

// ==== logic/layerPkg.sv ====
`default_nettype none

package layerPkg;

	localparam int numInputs = 15;
	localparam int numNeurons = 4;
	localparam int wordsPerNeuron = 16; // 15 weights then the bias
	localparam int romDepth = numNeurons * wordsPerNeuron;
	localparam int romAddrWidth = 6;
	localparam int actWidth = 8;
	localparam int sumWidth = 23;

	localparam logic [1:0] arbIdle = 2'd0;
	localparam logic [1:0] arbRead = 2'd1;
	localparam logic [1:0] arbAck = 2'd2;

	localparam logic [2:0] engIdle = 3'd0;
	localparam logic [2:0] engFetch = 3'd1;
	localparam logic [2:0] engRelease = 3'd2; // waiting for coeffAck to fall
	localparam logic [2:0] engSum = 3'd3;
	localparam logic [2:0] engRelu = 3'd4;
	localparam logic [2:0] engDone = 3'd5;

	typedef union packed
	{
		logic signed [15:0] bias; // sign-extended into the sum
		logic [1:0][7:0] weight; // weight[0] holds the signed weight, weight[1] is zero
	} romWord_t;

	function automatic romWord_t weightWord(input int value);
		romWord_t word;
		word.weight[1] = 8'h00;
		word.weight[0] = value[7:0];
		return word;
	endfunction

	function automatic romWord_t biasWord(input int value);
		romWord_t word;
		word.bias = value[15:0];
		return word;
	endfunction

	// neuron n owns words n*16 .. n*16+15, bias last
	localparam romWord_t coeffTable [romDepth] = '{
		weightWord(-54), weightWord(-12), weightWord(40), weightWord(-18), weightWord(24),
		weightWord(10), weightWord(12), weightWord(-12), weightWord(-32), weightWord(-34),
		weightWord(16), weightWord(-28), weightWord(36), weightWord(24), weightWord(18),
		biasWord(512),
		weightWord(20), weightWord(-35), weightWord(7), weightWord(50), weightWord(-8),
		weightWord(-60), weightWord(33), weightWord(-15), weightWord(44), weightWord(-2),
		weightWord(-27), weightWord(19), weightWord(5), weightWord(-41), weightWord(12),
		biasWord(-300),
		weightWord(-5), weightWord(9), weightWord(-14), weightWord(22), weightWord(3),
		weightWord(-30), weightWord(17), weightWord(-11), weightWord(6), weightWord(28),
		weightWord(-19), weightWord(2), weightWord(-7), weightWord(13), weightWord(-25),
		biasWord(20000), // saturates unless the products pull hard negative
		weightWord(63), weightWord(-64), weightWord(31), weightWord(-32), weightWord(15),
		weightWord(-16), weightWord(7), weightWord(-8), weightWord(3), weightWord(-4),
		weightWord(1), weightWord(-2), weightWord(90), weightWord(-90), weightWord(45),
		biasWord(96) // bit 5 set, rounds up on zero input
	};

endpackage

`default_nettype wire

// ==== logic/neuronEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronEngine
#(
	parameter int neuronIndex = 0
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic signed [layerPkg::actWidth-1:0] act [layerPkg::numInputs],
	output logic coeffReq,
	output logic [layerPkg::romAddrWidth-1:0] coeffAddr,
	input logic coeffAck,
	input layerPkg::romWord_t coeffData,
	output logic done,
	output logic [layerPkg::actWidth-1:0] result
);
	import layerPkg::*;

	logic [2:0] state;
	logic [$clog2(wordsPerNeuron)-1:0] wordIdx;
	logic lastWord;

	logic signed [actWidth-1:0] actReg [numInputs];
	logic signed [7:0] weights [numInputs];
	logic signed [15:0] bias;
	logic signed [sumWidth-1:0] sum;
	logic signed [sumWidth-1:0] sumNext;

	assign lastWord = (wordIdx == wordsPerNeuron - 1);
	assign coeffAddr = romAddrWidth'(neuronIndex * wordsPerNeuron) + romAddrWidth'(wordIdx);

	always_comb
	begin
		sumNext = bias; // signed, so this sign-extends
		for (int i = 0; i < numInputs; i++)
			sumNext = sumNext + actReg[i] * weights[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= engIdle;
			wordIdx <= '0;
			coeffReq <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			case (state)
				engIdle:
					if (start)
					begin
						wordIdx <= '0;
						coeffReq <= 1'b1;
						state <= engFetch;
					end
				engFetch:
					if (coeffAck)
					begin
						coeffReq <= 1'b0;
						state <= engRelease;
					end
				engRelease:
					if (!coeffAck)
					begin
						if (lastWord)
							state <= engSum;
						else
						begin
							wordIdx <= wordIdx + 1'b1;
							coeffReq <= 1'b1;
							state <= engFetch;
						end
					end
				engSum: state <= engRelu;
				engRelu:
				begin
					if (sum[sumWidth-1])
						result <= '0;
					else if (sum[sumWidth-2:13] != '0)
						result <= 8'd127; // too big for the output range
					else
						result <= sum[13:6] + 8'(sum[5]);
					done <= 1'b1;
					state <= engDone;
				end
				engDone:
					if (!start)
					begin
						done <= 1'b0;
						state <= engIdle;
					end
				default: state <= engIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == engIdle && start)
			actReg <= act;
		if (state == engFetch && coeffAck)
		begin
			if (lastWord)
				bias <= coeffData.bias;
			else
				weights[wordIdx] <= coeffData.weight[0];
		end
		if (state == engSum)
			sum <= sumNext;
	end

endmodule

`default_nettype wire

// ==== logic/neuronLayer.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronLayer
(
	input logic clk,
	input logic reset,
	input logic req,
	output logic ack,
	input logic signed [layerPkg::actWidth-1:0] act [layerPkg::numInputs],
	output logic [layerPkg::actWidth-1:0] result [layerPkg::numNeurons]
);
	import layerPkg::*;

	logic [numNeurons-1:0] done;
	logic [numNeurons-1:0] coeffReq;
	logic [numNeurons-1:0] coeffAck;
	logic [romAddrWidth-1:0] coeffAddr [numNeurons];
	romWord_t coeffData;
	logic [romAddrWidth-1:0] romAddr;
	romWord_t romData;

	for (genvar n = 0; n < numNeurons; n++)
	begin : genEngine
		neuronEngine #(.neuronIndex(n)) engine
		(
			.clk(clk),
			.reset(reset),
			.start(req), // engines hold done until req drops
			.act(act),
			.coeffReq(coeffReq[n]),
			.coeffAddr(coeffAddr[n]),
			.coeffAck(coeffAck[n]),
			.coeffData(coeffData),
			.done(done[n]),
			.result(result[n])
		);
	end

	coeffArbiter arbiter
	(
		.clk(clk),
		.reset(reset),
		.coeffReq(coeffReq),
		.coeffAddr(coeffAddr),
		.coeffAck(coeffAck),
		.coeffData(coeffData),
		.romAddr(romAddr),
		.romData(romData)
	);

	coeffRom rom
	(
		.clk(clk),
		.addr(romAddr),
		.data(romData)
	);

	// ack follows all engines done, and falls as soon as req is gone
	always_ff @(posedge clk)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= req && (&done);
	end

endmodule

`default_nettype wire

// ==== project.f ====
logic/layerPkg.sv
logic/coeffRom.sv
logic/coeffArbiter.sv
logic/neuronEngine.sv
logic/neuronLayer.sv
bench/neuronLayerTb.sv
